// File: src/lsu_pkg.sv
package lsu_pkg;

  // Bus widths
  localparam int addr_bits = 32;
  localparam int data_bits = 32;
  localparam int strb_bits = data_bits / 8;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [data_bits-1:0] data_t;
  typedef logic [strb_bits-1:0] strb_t;

  // Access width as seen by the pipeline
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // On-chip SRAM geometry
  localparam int sram_words      = 1024;
  localparam int sram_index_bits = $clog2(sram_words);
  localparam addr_t sram_bytes   = addr_t'(sram_words * strb_bits);  // First address out of range

  typedef logic [sram_index_bits-1:0] sram_index_t;

  typedef enum logic [2:0] {
    st_idle,
    st_raddr,   // ar channel
    st_rdata,   // r channel
    st_waddr,   // aw and w channels together
    st_bresp,   // b channel
    st_done     // result registered, done pulse follows
  } lsu_state_t;

endpackage

// File: src/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
  input  logic [1:0]          addr_low,
  input  lsu_pkg::mem_size_t  size,
  input  lsu_pkg::data_t      store_data,
  output lsu_pkg::data_t      lane_data,
  output lsu_pkg::strb_t      strobe
);

  // Data is copied to every lane, the strobe picks the lanes that count
  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        lane_data = {4{store_data[7:0]}};
        strobe    = lsu_pkg::strb_t'(4'b0001 << addr_low);
      end
      lsu_pkg::size_half: begin
        lane_data = {2{store_data[15:0]}};
        if (addr_low[1]) begin
          strobe = 4'b1100;  // Upper halfword
        end else begin
          strobe = 4'b0011;
        end
      end
      default: begin
        lane_data = store_data;
        strobe    = 4'b1111;
      end
    endcase
  end

endmodule

// File: src/lsu_load_extract.sv
`timescale 1ns/1ps

module lsu_load_extract (
  input  logic [1:0]          addr_low,
  input  lsu_pkg::mem_size_t  size,
  input  logic                zero_ext,
  input  lsu_pkg::data_t      bus_data,
  output lsu_pkg::data_t      load_data
);

  lsu_pkg::data_t shifted;
  logic           fill;

  // Addressed lane moved down to bit 0
  assign shifted = bus_data >> {addr_low, 3'b000};

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        fill      = zero_ext ? 1'b0 : shifted[7];
        load_data = {{24{fill}}, shifted[7:0]};
      end
      lsu_pkg::size_half: begin
        fill      = zero_ext ? 1'b0 : shifted[15];
        load_data = {{16{fill}}, shifted[15:0]};
      end
      default: begin
        fill      = 1'b0;  // Not used for a word
        load_data = bus_data;
      end
    endcase
  end

endmodule

// File: src/lsu.sv
`timescale 1ns/1ps

module lsu (
  input  logic                clock,
  input  logic                reset,

  input  logic                req_valid,
  input  logic                req_write,
  input  lsu_pkg::addr_t      req_addr,
  input  lsu_pkg::data_t      req_wdata,
  input  lsu_pkg::mem_size_t  req_size,
  input  logic                req_unsigned,
  output logic                busy,
  output logic                read_done,
  output logic                write_done,
  output lsu_pkg::data_t      rdata,
  output logic                error,

  output lsu_pkg::addr_t      araddr,
  output logic                arvalid,
  input  logic                arready,
  input  lsu_pkg::data_t      axi_rdata,
  input  lsu_pkg::resp_t      rresp,
  input  logic                rvalid,
  output logic                rready,

  output lsu_pkg::addr_t      awaddr,
  output logic                awvalid,
  input  logic                awready,
  output lsu_pkg::data_t      wdata,
  output lsu_pkg::strb_t      wstrb,
  output logic                wvalid,
  input  logic                wready,
  input  lsu_pkg::resp_t      bresp,
  input  logic                bvalid,
  output logic                bready
);

  lsu_pkg::lsu_state_t state;

  // Captured request
  logic               write_q;
  lsu_pkg::addr_t     addr_q;
  lsu_pkg::data_t     wdata_q;
  lsu_pkg::mem_size_t size_q;
  logic               unsigned_q;

  lsu_pkg::data_t bus_q;   // Raw read word
  lsu_pkg::resp_t resp_q;
  lsu_pkg::data_t load_data;

  logic accept;
  logic misaligned;
  logic aw_ok;
  logic w_ok;

  assign busy   = (state != lsu_pkg::st_idle) || read_done || write_done;
  assign accept = req_valid && !busy;

  always_comb begin
    case (req_size)
      lsu_pkg::size_byte: misaligned = 1'b0;
      lsu_pkg::size_half: misaligned = req_addr[0];
      default:            misaligned = (req_addr[1:0] != 2'b00);
    endcase
  end

  assign araddr = {addr_q[31:2], 2'b00};
  assign awaddr = {addr_q[31:2], 2'b00};

  // Write side finished once both channels are accepted
  assign aw_ok = !awvalid || awready;
  assign w_ok  = !wvalid || wready;

  lsu_store_align u_store_align (
    .addr_low   (addr_q[1:0]),
    .size       (size_q),
    .store_data (wdata_q),
    .lane_data  (wdata),
    .strobe     (wstrb)
  );

  lsu_load_extract u_load_extract (
    .addr_low  (addr_q[1:0]),
    .size      (size_q),
    .zero_ext  (unsigned_q),
    .bus_data  (bus_q),
    .load_data (load_data)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= lsu_pkg::st_idle;
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      bready     <= 1'b0;
      read_done  <= 1'b0;
      write_done <= 1'b0;
      error      <= 1'b0;
    end else begin
      read_done  <= 1'b0;
      write_done <= 1'b0;
      case (state)
        lsu_pkg::st_idle: begin
          if (accept) begin
            if (misaligned) begin  // Refused, no bus traffic
              error      <= 1'b1;
              read_done  <= !req_write;
              write_done <= req_write;
            end else if (req_write) begin
              awvalid <= 1'b1;
              wvalid  <= 1'b1;
              state   <= lsu_pkg::st_waddr;
            end else begin
              arvalid <= 1'b1;
              state   <= lsu_pkg::st_raddr;
            end
          end
        end
        lsu_pkg::st_raddr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= lsu_pkg::st_rdata;
          end
        end
        lsu_pkg::st_rdata: begin
          if (rvalid) begin
            rready <= 1'b0;
            state  <= lsu_pkg::st_done;
          end
        end
        lsu_pkg::st_waddr: begin
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if (aw_ok && w_ok) begin
            bready <= 1'b1;
            state  <= lsu_pkg::st_bresp;
          end
        end
        lsu_pkg::st_bresp: begin
          if (bvalid) begin
            bready <= 1'b0;
            state  <= lsu_pkg::st_done;
          end
        end
        lsu_pkg::st_done: begin
          error      <= (resp_q != lsu_pkg::resp_okay);
          read_done  <= !write_q;
          write_done <= write_q;
          state      <= lsu_pkg::st_idle;
        end
        default: state <= lsu_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      write_q    <= req_write;
      addr_q     <= req_addr;
      wdata_q    <= req_wdata;
      size_q     <= req_size;
      unsigned_q <= req_unsigned;
    end
    if (rvalid && rready) begin
      bus_q  <= axi_rdata;
      resp_q <= rresp;
    end
    if (bvalid && bready) resp_q <= bresp;
    if (state == lsu_pkg::st_done && !write_q) begin
      rdata <= load_data;
    end else if (accept && misaligned && !req_write) begin
      rdata <= '0;
    end
  end

endmodule

// File: src/axi_lite_sram.sv
`timescale 1ns/1ps

module axi_lite_sram (
  input  logic            clock,
  input  logic            reset,

  input  lsu_pkg::addr_t  araddr,
  input  logic            arvalid,
  output logic            arready,
  output lsu_pkg::data_t  rdata,
  output lsu_pkg::resp_t  rresp,
  output logic            rvalid,
  input  logic            rready,

  input  lsu_pkg::addr_t  awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  lsu_pkg::data_t  wdata,
  input  lsu_pkg::strb_t  wstrb,
  input  logic            wvalid,
  output logic            wready,
  output lsu_pkg::resp_t  bresp,
  output logic            bvalid,
  input  logic            bready
);

  lsu_pkg::data_t mem [lsu_pkg::sram_words];

  // Write address and data may arrive on different edges
  logic           aw_taken;
  logic           w_taken;
  lsu_pkg::addr_t awaddr_q;
  lsu_pkg::data_t wdata_q;
  lsu_pkg::strb_t wstrb_q;

  logic                 ar_hs;
  logic                 aw_hs;
  logic                 w_hs;
  logic                 do_write;
  lsu_pkg::addr_t       wr_addr;
  lsu_pkg::data_t       wr_data;
  lsu_pkg::strb_t       wr_strb;
  logic                 rd_in_range;
  logic                 wr_in_range;
  lsu_pkg::sram_index_t rd_index;
  lsu_pkg::sram_index_t wr_index;

  assign arready = !rvalid;
  assign awready = !bvalid && !aw_taken;
  assign wready  = !bvalid && !w_taken;

  assign ar_hs = arvalid && arready;
  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  // Either the latched beat or the one on the bus now
  assign wr_addr  = aw_taken ? awaddr_q : awaddr;
  assign wr_data  = w_taken ? wdata_q : wdata;
  assign wr_strb  = w_taken ? wstrb_q : wstrb;
  assign do_write = (aw_taken || aw_hs) && (w_taken || w_hs);

  assign rd_in_range = (araddr < lsu_pkg::sram_bytes);
  assign wr_in_range = (wr_addr < lsu_pkg::sram_bytes);
  assign rd_index    = lsu_pkg::sram_index_t'(araddr >> 2);
  assign wr_index    = lsu_pkg::sram_index_t'(wr_addr >> 2);

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid   <= 1'b0;
      bvalid   <= 1'b0;
      aw_taken <= 1'b0;
      w_taken  <= 1'b0;
    end else begin
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (do_write) begin
        bvalid   <= 1'b1;
        aw_taken <= 1'b0;
        w_taken  <= 1'b0;
      end else begin
        if (aw_hs) aw_taken <= 1'b1;
        if (w_hs) w_taken <= 1'b1;
        if (bready) bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_hs) awaddr_q <= awaddr;
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (ar_hs) begin
      rdata <= rd_in_range ? mem[rd_index] : '0;
      rresp <= rd_in_range ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
    end
    if (do_write) begin
      bresp <= wr_in_range ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
      if (wr_in_range) begin
        for (int i = 0; i < lsu_pkg::strb_bits; i++) begin
          if (wr_strb[i]) mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];  // Strobed lanes only
        end
      end
    end
  end

endmodule

// File: src/lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem (
  input  logic                clock,
  input  logic                reset,
  input  logic                req_valid,
  input  logic                req_write,
  input  lsu_pkg::addr_t      req_addr,
  input  lsu_pkg::data_t      req_wdata,
  input  lsu_pkg::mem_size_t  req_size,
  input  logic                req_unsigned,
  output logic                busy,
  output logic                read_done,
  output logic                write_done,
  output lsu_pkg::data_t      rdata,
  output logic                error
);

  // AXI4-Lite between LSU and SRAM
  lsu_pkg::addr_t araddr;
  logic           arvalid;
  logic           arready;
  lsu_pkg::data_t axi_rdata;
  lsu_pkg::resp_t rresp;
  logic           rvalid;
  logic           rready;
  lsu_pkg::addr_t awaddr;
  logic           awvalid;
  logic           awready;
  lsu_pkg::data_t wdata;
  lsu_pkg::strb_t wstrb;
  logic           wvalid;
  logic           wready;
  lsu_pkg::resp_t bresp;
  logic           bvalid;
  logic           bready;

  lsu u_lsu (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_size     (req_size),
    .req_unsigned (req_unsigned),
    .busy         (busy),
    .read_done    (read_done),
    .write_done   (write_done),
    .rdata        (rdata),
    .error        (error),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .axi_rdata    (axi_rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  axi_lite_sram u_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (axi_rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

// File: bench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam int model_bits   = $clog2(4 * lsu_pkg::sram_words);
  localparam int region_words = 64;  // Words the tests work in
  localparam int wait_limit   = 50;

  logic               clock;
  logic               reset;
  logic               req_valid;
  logic               req_write;
  lsu_pkg::addr_t     req_addr;
  lsu_pkg::data_t     req_wdata;
  lsu_pkg::mem_size_t req_size;
  logic               req_unsigned;
  logic               busy;
  logic               read_done;
  logic               write_done;
  lsu_pkg::data_t     rdata;
  logic               error;

  logic [7:0] model_mem [4 * lsu_pkg::sram_words];  // Byte image of the SRAM
  int         error_count;
  int         timeout_count;

  lsu_subsystem u_lsu_subsystem (
    .clock        (clock),
    .reset        (reset),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_size     (req_size),
    .req_unsigned (req_unsigned),
    .busy         (busy),
    .read_done    (read_done),
    .write_done   (write_done),
    .rdata        (rdata),
    .error        (error)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic int size_bytes(lsu_pkg::mem_size_t size);
    case (size)
      lsu_pkg::size_byte: return 1;
      lsu_pkg::size_half: return 2;
      default:            return 4;
    endcase
  endfunction

  // Little endian, bytes counted up from the addressed lane
  function automatic void model_store(lsu_pkg::addr_t addr, lsu_pkg::mem_size_t size,
      lsu_pkg::data_t value);
    for (int k = 0; k < size_bytes(size); k++) begin
      model_mem[{addr[model_bits-1:2], 2'(int'(addr[1:0]) + k)}] = value[8*k +: 8];
    end
  endfunction

  function automatic lsu_pkg::data_t expected_load(lsu_pkg::addr_t addr,
      lsu_pkg::mem_size_t size, logic zero_ext);
    lsu_pkg::data_t value;
    int             n;
    value = 32'h0;
    n     = size_bytes(size);
    for (int k = 0; k < n; k++) begin
      value[8*k +: 8] = model_mem[{addr[model_bits-1:2], 2'(int'(addr[1:0]) + k)}];
    end
    if (!zero_ext && n < 4 && value[8*n-1]) value = value | (32'hffff_ffff << (8 * n));
    return value;
  endfunction

  task automatic compare_data(input string test, input lsu_pkg::data_t expected,
      input lsu_pkg::data_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_error(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected error %b, actual %b", test, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_cycles(input string test, input int expected, input int actual);
    if (actual != expected) begin
      $display("[ERROR] %s: expected %0d cycles, actual %0d", test, expected, actual);
      error_count++;
    end
  endtask

  // Holds req_valid until an edge with busy low, then waits for the done pulse
  task automatic do_request(input logic write, input lsu_pkg::addr_t addr,
      input lsu_pkg::mem_size_t size, input logic zero_ext, input lsu_pkg::data_t value,
      output lsu_pkg::data_t result, output logic err, output int cycles);
    logic idle_before;
    logic accepted;
    logic done;
    int   waited;
    result   = 32'h0;
    err      = 1'b0;
    cycles   = -1;
    accepted = 1'b0;
    done     = 1'b0;
    waited   = 0;
    @(posedge clock);
    req_valid    <= 1'b1;
    req_write    <= write;
    req_addr     <= addr;
    req_wdata    <= value;
    req_size     <= size;
    req_unsigned <= zero_ext;
    while (!accepted && waited < wait_limit) begin
      @(negedge clock);
      idle_before = !busy;
      @(posedge clock);
      waited++;
      if (idle_before) begin
        req_valid <= 1'b0;
        accepted = 1'b1;
      end
    end
    if (!accepted) begin
      $display("Timeout: the request to address %h was never accepted", addr);
      timeout_count++;
      req_valid <= 1'b0;
      return;
    end
    waited = 0;
    while (!done && waited < wait_limit) begin
      @(negedge clock);
      waited++;
      if (waited == 1 && !busy) begin
        $display("busy stayed low after the request to address %h was accepted", addr);
        error_count++;
      end
      if (read_done || write_done) begin
        done = 1'b1;
        if (write_done !== write || read_done === write) begin
          $display("Wrong done pulse for the request to address %h", addr);
          error_count++;
        end
        result = rdata;
        err    = error;
        cycles = waited;
      end
    end
    if (!done) begin
      $display("Timeout: no done pulse for the request to address %h", addr);
      timeout_count++;
    end
  endtask

  task automatic store_and_track(input string test, input lsu_pkg::addr_t addr,
      input lsu_pkg::mem_size_t size, input lsu_pkg::data_t value);
    lsu_pkg::data_t result;
    logic           err;
    int             cycles;
    do_request(1'b1, addr, size, 1'b0, value, result, err, cycles);
    model_store(addr, size, value);
    compare_error(test, 1'b0, err);
    compare_cycles(test, 4, cycles);
  endtask

  task automatic load_and_verify(input string test, input lsu_pkg::addr_t addr,
      input lsu_pkg::mem_size_t size, input logic zero_ext);
    lsu_pkg::data_t result;
    logic           err;
    int             cycles;
    do_request(1'b0, addr, size, zero_ext, 32'h0, result, err, cycles);
    compare_data(test, expected_load(addr, size, zero_ext), result);
    compare_error(test, 1'b0, err);
    compare_cycles(test, 4, cycles);
  endtask

  // Model is left alone, the DUT must not touch memory
  task automatic refused_request(input string test, input logic write,
      input lsu_pkg::addr_t addr, input lsu_pkg::mem_size_t size, input int latency,
      output lsu_pkg::data_t result);
    logic err;
    int   cycles;
    do_request(write, addr, size, 1'b0, $urandom(), result, err, cycles);
    compare_error(test, 1'b1, err);
    compare_cycles(test, latency, cycles);
  endtask

  task automatic idle_after_reset();
    for (int i = 0; i < 8; i++) begin
      @(negedge clock);
      if (busy || read_done || write_done) begin
        $display("busy or a done pulse was high with no request after reset");
        error_count++;
      end
    end
    store_and_track("first word store", 32'h10, lsu_pkg::size_word, 32'hcafe_f00d);
    load_and_verify("first word load", 32'h10, lsu_pkg::size_word, 1'b0);
  endtask

  task automatic fill_region();
    lsu_pkg::addr_t addr;
    for (int w = 0; w < region_words; w++) begin
      addr = lsu_pkg::addr_t'(4 * w);
      store_and_track("region fill", addr, lsu_pkg::size_word,
        (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f);
    end
  endtask

  task automatic store_lanes();
    for (int off = 0; off < 4; off++) begin
      store_and_track($sformatf("byte store offset %0d", off), lsu_pkg::addr_t'(32'h40 + off),
        lsu_pkg::size_byte, $urandom());
      load_and_verify($sformatf("word after byte store %0d", off), 32'h40, lsu_pkg::size_word,
        1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      store_and_track($sformatf("half store offset %0d", off), lsu_pkg::addr_t'(32'h44 + off),
        lsu_pkg::size_half, $urandom());
      load_and_verify($sformatf("word after half store %0d", off), 32'h44, lsu_pkg::size_word,
        1'b0);
    end
  endtask

  task automatic load_extension();
    lsu_pkg::mem_size_t size;
    lsu_pkg::data_t     value;
    lsu_pkg::addr_t     addr;
    for (int s = 0; s < 2; s++) begin
      size = (s == 0) ? lsu_pkg::size_byte : lsu_pkg::size_half;
      for (int off = 0; off < 4; off += size_bytes(size)) begin
        for (int msb = 0; msb < 2; msb++) begin
          value = $urandom();
          value[8 * (off + size_bytes(size)) - 1] = (msb == 1);  // Sign bit of the field
          addr = lsu_pkg::addr_t'(32'h80 + off);
          store_and_track("extension setup", 32'h80, lsu_pkg::size_word, value);
          load_and_verify($sformatf("signed load size %0d offset %0d", s, off), addr, size,
            1'b0);
          load_and_verify($sformatf("unsigned load size %0d offset %0d", s, off), addr, size,
            1'b1);
        end
      end
    end
  endtask

  task automatic misaligned_refusal();
    lsu_pkg::data_t result;
    lsu_pkg::addr_t addr;
    for (int off = 1; off < 4; off++) begin
      addr = lsu_pkg::addr_t'(32'hc0 + off);
      if (off != 2) begin
        refused_request("misaligned half store", 1'b1, addr, lsu_pkg::size_half, 1, result);
        refused_request("misaligned half load", 1'b0, addr, lsu_pkg::size_half, 1, result);
      end
      refused_request("misaligned word store", 1'b1, addr, lsu_pkg::size_word, 1, result);
      refused_request("misaligned word load", 1'b0, addr, lsu_pkg::size_word, 1, result);
      load_and_verify("word after misaligned stores", 32'hc0, lsu_pkg::size_word, 1'b0);
    end
  endtask

  task automatic out_of_range();
    lsu_pkg::addr_t far;
    lsu_pkg::data_t result;
    far = lsu_pkg::addr_t'(4 * lsu_pkg::sram_words);  // First byte past the array
    refused_request("load past the SRAM", 1'b0, far, lsu_pkg::size_word, 4, result);
    compare_data("load past the SRAM", 32'h0, result);
    refused_request("load at the top address", 1'b0, 32'hffff_fffc, lsu_pkg::size_word, 4,
      result);
    compare_data("load at the top address", 32'h0, result);
    refused_request("store past the SRAM", 1'b1, far, lsu_pkg::size_word, 4, result);
    refused_request("byte store past the SRAM", 1'b1, far + 32'h9, lsu_pkg::size_byte, 4,
      result);
    load_and_verify("word 0 after far stores", 32'h0, lsu_pkg::size_word, 1'b0);
    load_and_verify("word 2 after far stores", 32'h8, lsu_pkg::size_word, 1'b0);
  endtask

  task automatic random_traffic();
    lsu_pkg::mem_size_t size;
    lsu_pkg::addr_t     addr;
    int unsigned        pick;
    int unsigned        off;
    for (int i = 0; i < 40; i++) begin
      pick = $urandom_range(2, 0);
      size = (pick == 0) ? lsu_pkg::size_byte :
             (pick == 1) ? lsu_pkg::size_half : lsu_pkg::size_word;
      off  = (pick == 0) ? $urandom_range(3, 0) : (pick == 1) ? 2 * $urandom_range(1, 0) : 0;
      addr = lsu_pkg::addr_t'(4 * $urandom_range(region_words - 1, 0) + off);
      if ($urandom_range(1, 0) == 1) begin
        store_and_track($sformatf("random store %0d", i), addr, size, $urandom());
      end else begin
        load_and_verify($sformatf("random load %0d", i), addr, size, $urandom_range(1, 0) == 1);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h4c93));
    error_count   = 0;
    timeout_count = 0;
    reset         = 1'b1;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_addr      = 32'h0;
    req_wdata     = 32'h0;
    req_size      = lsu_pkg::size_word;
    req_unsigned  = 1'b0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    idle_after_reset();
    fill_region();
    store_lanes();
    load_extension();
    misaligned_refusal();
    out_of_range();
    random_traffic();
    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_load_extract.sv
src/lsu.sv
src/axi_lite_sram.sv
src/lsu_subsystem.sv
bench/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Compile the testbench with Verilator, run it, and pass only if the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsu_tb -f build.f -o lsu_sim || exit 1

out=$(./obj_dir/lsu_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Result: PASSED" && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
